/* rtl/sonar_defs.svh */
`ifndef SONAR_DEFS_SVH
`define SONAR_DEFS_SVH

////////////////////////////////////////
// sensor array
////////////////////////////////////////

// six sensors at odd multiples of 15 degrees
`define SONAR_SENSORS 6

////////////////////////////////////////
// ranging timing
////////////////////////////////////////

// trigger pulse length in clock cycles
`define SONAR_TRIGGER_CYCLES 10

// echo cycles per distance unit, small so simulation stays short
`define SONAR_CYCLES_PER_UNIT 4

// quiet gap before each run in clock cycles
`define SONAR_SETTLE_CYCLES 16

// distance code for no echo or an echo past 254 units
`define SONAR_NO_ECHO 8'hff

////////////////////////////////////////
// register map, word addresses
////////////////////////////////////////

`define REG_CONTROL 2'd0
`define REG_STATUS 2'd1
`define REG_LOCATION 2'd2

`endif

/* rtl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

   ////////////////////////////////////////
   // wishbone classic types
   ////////////////////////////////////////

   // word address, four registers at most
   typedef logic [1:0] wb_addr_t;

   // data bus width
   typedef logic [31:0] wb_data_t;

   // master to slave, held while cyc and stb are high
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat;
   } wb_req_t;

   // slave to master
   // read data is valid in the ack cycle
   typedef struct packed {
      logic     ack;
      wb_data_t dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

/* rtl/sonar_pkg.sv */
`default_nettype none

package sonar_pkg;

   ////////////////////////////////////////
   // ranging values
   ////////////////////////////////////////

   // distance in units, all ones means nothing seen
   typedef logic [7:0] distance_t;

   // angle in units of 15 degrees, always odd for a real sensor
   typedef logic [3:0] angle_t;

   // index of one of the six sensors
   typedef logic [2:0] sensor_t;

   // reported location, angle sits above distance
   typedef struct packed {
      angle_t    angle;
      distance_t distance;
   } location_t;

   ////////////////////////////////////////
   // state machines
   ////////////////////////////////////////

   // sweep over all sensors
   typedef enum logic [1:0] {
      sweep_idle,
      sweep_run,
      sweep_wait,
      sweep_report
   } sweep_state_t;

   // one trigger and echo measurement
   typedef enum logic [1:0] {
      ranger_idle,
      ranger_trigger,
      ranger_listen,
      ranger_measure
   } ranger_state_t;

endpackage

`default_nettype wire

/* rtl/echo_ranger.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sonar_defs.svh"

module echo_ranger (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 start,
   input  sonar_pkg::sensor_t   sensor,
   input  logic [5:0]           echo,
   output logic [5:0]           trigger,
   output sonar_pkg::distance_t distance,
   output logic                 done
);

   localparam int trig_w = $clog2(`SONAR_TRIGGER_CYCLES + 1);
   localparam int pre_w  = $clog2(`SONAR_CYCLES_PER_UNIT);
   // last count before the unit counter saturates
   localparam sonar_pkg::distance_t last_unit = sonar_pkg::distance_t'(`SONAR_NO_ECHO - 1);

   sonar_pkg::ranger_state_t state;
   logic [trig_w-1:0]        trig_count;
   logic [pre_w-1:0]         prescale;
   sonar_pkg::distance_t     units;
   logic                     echo_bit;
   logic                     unit_tick;

   // only the selected sensor is listened to
   assign echo_bit  = echo[sensor];
   // prescaler wraps once per distance unit
   assign unit_tick = (prescale == pre_w'(`SONAR_CYCLES_PER_UNIT - 1));
   // trigger only on the selected pin, only while in the trigger state
   assign trigger   = (state == sonar_pkg::ranger_trigger) ? (6'b000001 << sensor) : 6'b000000;

   always_ff @(posedge clock) begin
      if (reset) begin
         state      <= sonar_pkg::ranger_idle;
         trig_count <= '0;
         prescale   <= '0;
         units      <= '0;
         distance   <= '0;
         done       <= 1'b0;
      end else begin
         // done is a single cycle pulse
         done <= 1'b0;
         case (state)
            sonar_pkg::ranger_trigger: begin
               trig_count <= trig_count + 1'b1;
               if (trig_count == trig_w'(`SONAR_TRIGGER_CYCLES - 1)) begin
                  state    <= sonar_pkg::ranger_listen;
                  prescale <= '0;
                  units    <= '0;
               end
            end
            sonar_pkg::ranger_listen: begin
               if (echo_bit) begin
                  // the rising cycle already counts as echo time
                  state    <= sonar_pkg::ranger_measure;
                  prescale <= pre_w'(1);
                  units    <= '0;
               end else if (unit_tick) begin
                  prescale <= '0;
                  if (units == last_unit) begin
                     // echo never came back
                     distance <= `SONAR_NO_ECHO;
                     done     <= 1'b1;
                     state    <= sonar_pkg::ranger_idle;
                  end else begin
                     units <= units + 1'b1;
                  end
               end else begin
                  prescale <= prescale + 1'b1;
               end
            end
            sonar_pkg::ranger_measure: begin
               if (!echo_bit) begin
                  // falling edge, whole units counted so far
                  distance <= units;
                  done     <= 1'b1;
                  state    <= sonar_pkg::ranger_idle;
               end else if (unit_tick) begin
                  prescale <= '0;
                  if (units == last_unit) begin
                     // still high at 255 units, saturate
                     distance <= `SONAR_NO_ECHO;
                     done     <= 1'b1;
                     state    <= sonar_pkg::ranger_idle;
                  end else begin
                     units <= units + 1'b1;
                  end
               end else begin
                  prescale <= prescale + 1'b1;
               end
            end
            default: begin
               if (start) begin
                  state      <= sonar_pkg::ranger_trigger;
                  trig_count <= '0;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/median_of_three.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sonar_defs.svh"

module median_of_three (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 start,
   input  sonar_pkg::sensor_t   sensor,
   input  logic [5:0]           echo,
   output logic [5:0]           trigger,
   output sonar_pkg::distance_t distance,
   output logic                 done
);

   localparam int settle_w = $clog2(`SONAR_SETTLE_CYCLES + 1);

   typedef enum logic [1:0] {
      median_idle,
      median_settle,
      median_run
   } median_state_t;

   median_state_t        state;
   logic [settle_w-1:0]  settle_count;
   logic [1:0]           run_index;
   logic                 ranger_start;
   logic                 ranger_done;
   sonar_pkg::distance_t ranger_distance;
   // first two runs, the third goes straight into the compare
   sonar_pkg::distance_t results [0:1];

   // median by clamping c between the smaller and larger of a and b
   function automatic sonar_pkg::distance_t median3(input sonar_pkg::distance_t a, b, c);
      sonar_pkg::distance_t lo;
      sonar_pkg::distance_t hi;
      lo = (a < b) ? a : b;
      hi = (a < b) ? b : a;
      if (c < lo) return lo;
      if (c > hi) return hi;
      return c;
   endfunction

   echo_ranger echo_ranger_inst (
      .clock    (clock),
      .reset    (reset),
      .start    (ranger_start),
      .sensor   (sensor),
      .echo     (echo),
      .trigger  (trigger),
      .distance (ranger_distance),
      .done     (ranger_done)
   );

   ////////////////////////////////////////
   // run sequencing
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state        <= median_idle;
         settle_count <= '0;
         run_index    <= '0;
         ranger_start <= 1'b0;
         distance     <= '0;
         done         <= 1'b0;
      end else begin
         ranger_start <= 1'b0;
         done         <= 1'b0;
         case (state)
            median_settle: begin
               // quiet gap lets old echoes die out
               settle_count <= settle_count + 1'b1;
               if (settle_count == settle_w'(`SONAR_SETTLE_CYCLES - 1)) begin
                  ranger_start <= 1'b1;
                  state        <= median_run;
               end
            end
            median_run: begin
               if (ranger_done) begin
                  if (run_index == 2'd2) begin
                     distance <= median3(results[0], results[1], ranger_distance);
                     done     <= 1'b1;
                     state    <= median_idle;
                  end else begin
                     run_index    <= run_index + 1'b1;
                     settle_count <= '0;
                     state        <= median_settle;
                  end
               end
            end
            default: begin
               if (start) begin
                  run_index    <= '0;
                  settle_count <= '0;
                  state        <= median_settle;
               end
            end
         endcase
      end
   end

   // keep the first two results
   always_ff @(posedge clock) begin
      if (state == median_run && ranger_done && run_index != 2'd2) begin
         results[run_index[0]] <= ranger_distance;
      end
   end

endmodule

`default_nettype wire

/* rtl/sweep_locator.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sonar_defs.svh"

module sweep_locator (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 start,
   input  logic [5:0]           echo,
   output logic [5:0]           trigger,
   output logic [5:0]           power,
   output sonar_pkg::location_t location,
   output logic                 busy,
   output logic                 done
);

   // nothing found, reported as angle 1 distance 0
   localparam sonar_pkg::location_t no_target = 12'h100;

   sonar_pkg::sweep_state_t state;
   sonar_pkg::sensor_t      sensor;
   sonar_pkg::sensor_t      best_sensor;
   sonar_pkg::distance_t    best_distance;
   sonar_pkg::angle_t       best_angle;
   logic                    best_valid;
   logic                    median_start;
   logic                    median_done;
   sonar_pkg::distance_t    median_distance;
   logic                    last_sensor;

   median_of_three median_of_three_inst (
      .clock    (clock),
      .reset    (reset),
      .start    (median_start),
      .sensor   (sensor),
      .echo     (echo),
      .trigger  (trigger),
      .distance (median_distance),
      .done     (median_done)
   );

   assign last_sensor = (sensor == sonar_pkg::sensor_t'(`SONAR_SENSORS - 1));
   // sensor n sits at (2n + 1) times 15 degrees
   assign best_angle  = {best_sensor, 1'b1};
   assign busy        = (state != sonar_pkg::sweep_idle);

   // power only the sensor being ranged
   always_comb begin
      power = 6'b000000;
      if (state == sonar_pkg::sweep_run || state == sonar_pkg::sweep_wait) begin
         power = 6'b000001 << sensor;
      end
   end

   ////////////////////////////////////////
   // sweep FSM
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state         <= sonar_pkg::sweep_idle;
         sensor        <= '0;
         best_sensor   <= '0;
         best_distance <= '0;
         best_valid    <= 1'b0;
         median_start  <= 1'b0;
         location      <= '0;
         done          <= 1'b0;
      end else begin
         median_start <= 1'b0;
         done         <= 1'b0;
         case (state)
            sonar_pkg::sweep_run: begin
               median_start <= 1'b1;
               state        <= sonar_pkg::sweep_wait;
            end
            sonar_pkg::sweep_wait: begin
               if (median_done) begin
                  // first sensor always taken, later ones only if strictly closer
                  if (!best_valid || median_distance < best_distance) begin
                     best_distance <= median_distance;
                     best_sensor   <= sensor;
                     best_valid    <= 1'b1;
                  end
                  if (last_sensor) begin
                     state <= sonar_pkg::sweep_report;
                  end else begin
                     sensor <= sensor + 1'b1;
                     state  <= sonar_pkg::sweep_run;
                  end
               end
            end
            sonar_pkg::sweep_report: begin
               if (best_distance == `SONAR_NO_ECHO) begin
                  location <= no_target;
               end else begin
                  location.angle    <= best_angle;
                  location.distance <= best_distance;
               end
               done  <= 1'b1;
               state <= sonar_pkg::sweep_idle;
            end
            default: begin
               if (start) begin
                  sensor     <= '0;
                  best_valid <= 1'b0;
                  state      <= sonar_pkg::sweep_run;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/wb_locator_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sonar_defs.svh"

module wb_locator_regs (
   input  logic                 clock,
   input  logic                 reset,
   input  bus_pkg::wb_req_t     req,
   output bus_pkg::wb_rsp_t     rsp,
   input  logic                 busy,
   input  logic                 sweep_done,
   input  sonar_pkg::location_t location,
   output logic                 start
);

   logic                 ack;
   bus_pkg::wb_data_t    read_data;
   logic                 done_bit;
   sonar_pkg::location_t location_copy;
   logic                 access;
   logic                 start_write;
   logic                 start_issue;

   // new access, the ack cycle itself is not a second one
   assign access      = req.cyc && req.stb && !ack;
   assign start_write = access && req.we && (req.adr == `REG_CONTROL) && req.dat[0];
   // writes while busy are acked and dropped
   assign start_issue = start_write && !busy;

   assign rsp.ack = ack;
   assign rsp.dat = read_data;

   ////////////////////////////////////////
   // ack, start and result stage
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         ack           <= 1'b0;
         start         <= 1'b0;
         done_bit      <= 1'b0;
         location_copy <= '0;
      end else begin
         ack   <= access;
         start <= start_issue;
         // done clears on a new start, sets at the end of a sweep
         if (start_issue) begin
            done_bit <= 1'b0;
         end else if (sweep_done) begin
            done_bit <= 1'b1;
         end
         if (sweep_done) begin
            location_copy <= location;
         end
      end
   end

   // read mux, registered so data lines up with ack
   always_ff @(posedge clock) begin
      if (access) begin
         case (req.adr)
            `REG_STATUS:   read_data <= {30'd0, done_bit, busy};
            `REG_LOCATION: read_data <= {20'd0, location_copy};
            // control reads and the unused address return zero
            default:       read_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/sonar_locator_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sonar_locator_top (
   input  logic             clock,
   input  logic             reset,
   input  bus_pkg::wb_req_t wb_req,
   output bus_pkg::wb_rsp_t wb_rsp,
   input  logic [5:0]       echo,
   output logic [5:0]       trigger,
   output logic [5:0]       power
);

   // between the register block and the sweep
   logic                 start;
   logic                 busy;
   logic                 sweep_done;
   sonar_pkg::location_t location;

   // bus slave with the location result register
   wb_locator_regs wb_locator_regs_inst (
      .clock      (clock),
      .reset      (reset),
      .req        (wb_req),
      .rsp        (wb_rsp),
      .busy       (busy),
      .sweep_done (sweep_done),
      .location   (location),
      .start      (start)
   );

   // sweep over the six sensors
   sweep_locator sweep_locator_inst (
      .clock    (clock),
      .reset    (reset),
      .start    (start),
      .echo     (echo),
      .trigger  (trigger),
      .power    (power),
      .location (location),
      .busy     (busy),
      .done     (sweep_done)
   );

endmodule

`default_nettype wire

/* verification/sonar_locator_props.sv */
`timescale 1ns/1ps
`default_nettype none

module sonar_locator_props (
   input logic       clock,
   input logic       reset,
   input logic       ack,
   input logic [5:0] power,
   input logic [5:0] trigger
);

   ////////////////////////////////////////
   // bus and sensor pin rules
   ////////////////////////////////////////

   // ack is a single cycle pulse
   ack_single_cycle: assert property (@(posedge clock) disable iff (reset) ack |=> !ack)
      else $error("ack stayed high for more than one cycle");

   // at most one sensor powered at a time
   power_one_hot: assert property (@(posedge clock) disable iff (reset) $onehot0(power))
      else $error("more than one sensor powered");

   // a trigger pin only fires on the powered sensor
   trigger_on_powered: assert property (@(posedge clock) disable iff (reset)
      (trigger & ~power) == 6'b000000)
      else $error("trigger high on a sensor that is not powered");

endmodule

// attached to every instance of the top level
bind sonar_locator_top sonar_locator_props sonar_locator_props_inst (
   .clock   (clock),
   .reset   (reset),
   .ack     (wb_rsp.ack),
   .power   (power),
   .trigger (trigger)
);

`default_nettype wire

/* verification/sonar_locator_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sonar_defs.svh"

module sonar_locator_tb;

   localparam int clock_period = 4;
   // worst run: settle, trigger, late echo rise and a full length echo
   localparam int run_cycles = `SONAR_SETTLE_CYCLES + `SONAR_TRIGGER_CYCLES + 32
      + 2 * 255 * `SONAR_CYCLES_PER_UNIT;
   localparam int sweep_cycles = `SONAR_SENSORS * 3 * run_cycles + 64;
   localparam int timeout_ns = 20 * sweep_cycles * clock_period;

   // one distance per sensor, index 5 on the left
   typedef sonar_pkg::distance_t [5:0] distance_set_t;

   logic             clock;
   logic             reset;
   bus_pkg::wb_req_t wb_req;
   bus_pkg::wb_rsp_t wb_rsp;
   logic [5:0]       echo;
   logic [5:0]       trigger;
   logic [5:0]       power;

   // 255 means the sensor stays silent
   distance_set_t        sensor_distance;
   sonar_pkg::location_t expected_q[$];
   sonar_pkg::location_t observed_q[$];
   int                   expected_total = 0;
   int                   compared = 0;

   sonar_locator_top sonar_locator_top_inst (
      .clock   (clock),
      .reset   (reset),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .echo    (echo),
      .trigger (trigger),
      .power   (power)
   );

   initial begin
      clock = 1'b0;
      forever #(clock_period / 2) clock = ~clock;
   end

   ////////////////////////////////////////
   // reference model and helpers
   ////////////////////////////////////////

   // closest sensor wins, lowest index on a tie
   function automatic sonar_pkg::location_t expected_location(input distance_set_t dists);
      sonar_pkg::sensor_t best;
      best = '0;
      for (int i = 1; i < `SONAR_SENSORS; i++) begin
         if (dists[i] < dists[best]) begin
            best = sonar_pkg::sensor_t'(i);
         end
      end
      // nothing seen anywhere
      if (dists[best] == 8'd255) begin
         return 12'h100;
      end
      return {4'(2 * int'(best) + 1), dists[best]};
   endfunction

   // values 1 to 254, optionally all different
   function automatic distance_set_t random_distances(input bit distinct);
      distance_set_t set;
      bit            clash;
      set = '0;
      for (int i = 0; i < `SONAR_SENSORS; i++) begin
         do begin
            set[i] = sonar_pkg::distance_t'(1 + ($urandom % 254));
            clash = 1'b0;
            for (int j = 0; j < i; j++) begin
               if (distinct && set[j] == set[i]) begin
                  clash = 1'b1;
               end
            end
         end while (clash);
      end
      return set;
   endfunction

   function automatic sonar_pkg::sensor_t lowest_set_bit(input logic [5:0] vec);
      sonar_pkg::sensor_t idx;
      idx = '0;
      for (int i = 5; i >= 0; i--) begin
         if (vec[i]) begin
            idx = sonar_pkg::sensor_t'(i);
         end
      end
      return idx;
   endfunction

   task automatic abort_run(input string message);
      $display("%s", message);
      $display("test failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input bus_pkg::wb_data_t got, input bus_pkg::wb_data_t want,
                              input string what);
      assert (got == want) else begin
         abort_run($sformatf("CHECK FAILED at %0t ns: %s read %h, expected %h",
                             $time, what, got, want));
      end
   endtask

   ////////////////////////////////////////
   // wishbone master
   ////////////////////////////////////////

   // one classic cycle, ack expected exactly one cycle after stb
   task automatic bus_access(input logic write, input bus_pkg::wb_addr_t addr,
                             input bus_pkg::wb_data_t wdata, output bus_pkg::wb_data_t rdata);
      int waited;
      @(negedge clock);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = write;
      wb_req.adr = addr;
      wb_req.dat = wdata;
      waited = 0;
      do begin
         @(negedge clock);
         waited++;
      end while (!wb_rsp.ack && waited < 8);
      assert (wb_rsp.ack) else begin
         abort_run("bus access was never acknowledged");
      end
      check_value(32'(waited), 32'd1, "ack latency in cycles");
      rdata  = wb_rsp.dat;
      // drop the request in the ack cycle
      wb_req = '0;
   endtask

   task automatic write_register(input bus_pkg::wb_addr_t addr, input bus_pkg::wb_data_t data);
      bus_pkg::wb_data_t unused;
      bus_access(1'b1, addr, data, unused);
   endtask

   task automatic read_register(input bus_pkg::wb_addr_t addr, output bus_pkg::wb_data_t data);
      bus_access(1'b0, addr, 32'd0, data);
   endtask

   ////////////////////////////////////////
   // sweep sequencing
   ////////////////////////////////////////

   task automatic start_sweep(input distance_set_t dists);
      bus_pkg::wb_data_t status;
      sensor_distance = dists;
      expected_q.push_back(expected_location(dists));
      expected_total++;
      write_register(`REG_CONTROL, 32'd1);
      // busy now, done cleared by the start
      read_register(`REG_STATUS, status);
      check_value(status, 32'd1, "status after start");
   endtask

   task automatic finish_sweep();
      bus_pkg::wb_data_t status;
      bus_pkg::wb_data_t data;
      status = '0;
      // poll until done, busy and done never both set
      while (!status[1]) begin
         read_register(`REG_STATUS, status);
         check_value(32'(status[1] & status[0]), 32'd0, "busy and done together");
      end
      check_value(status, 32'd2, "status at end of sweep");
      read_register(`REG_LOCATION, data);
      check_value(data & 32'hffff_f000, 32'd0, "location upper bits");
      observed_q.push_back(data[11:0]);
   endtask

   task automatic run_sweep(input distance_set_t dists);
      start_sweep(dists);
      finish_sweep();
   endtask

   ////////////////////////////////////////
   // sensor echo model
   ////////////////////////////////////////

   // echo follows the falling trigger after a random gap
   initial begin : sensor_model
      logic [5:0]         last_trigger;
      sonar_pkg::sensor_t idx;
      int unsigned        gap;
      int                 width;
      int                 high_cycles;
      echo = '0;
      last_trigger = '0;
      high_cycles = 0;
      forever begin
         @(negedge clock);
         if (trigger != 6'd0) begin
            high_cycles++;
         end
         if (last_trigger != 6'd0 && trigger == 6'd0) begin
            // trigger pulse must last the full trigger time
            check_value(32'(high_cycles), 32'(`SONAR_TRIGGER_CYCLES),
                        "trigger pulse length");
            high_cycles = 0;
            idx = lowest_set_bit(last_trigger);
            if (power[idx] && sensor_distance[idx] != 8'd255) begin
               gap   = 1 + ($urandom % 20);
               width = int'(sensor_distance[idx]) * `SONAR_CYCLES_PER_UNIT;
               repeat (gap) @(negedge clock);
               echo[idx] = 1'b1;
               repeat (width) @(negedge clock);
               echo[idx] = 1'b0;
            end
         end
         last_trigger = trigger;
      end
   end

   // location reads against the reference, in order
   initial begin : compare
      sonar_pkg::location_t got;
      sonar_pkg::location_t want;
      forever begin
         @(posedge clock);
         while (observed_q.size() > 0 && expected_q.size() > 0) begin
            got  = observed_q.pop_front();
            want = expected_q.pop_front();
            assert (got == want) else begin
               abort_run($sformatf("CHECK FAILED at %0t ns: location %h, expected %h",
                                   $time, got, want));
            end
            compared++;
         end
      end
   end

   initial begin : watchdog
      #(timeout_ns);
      abort_run("timeout, the sweeps did not finish in the allowed time");
   end

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin : stimulus
      bus_pkg::wb_data_t data;
      distance_set_t     dists;
      void'($urandom(32'h18a0efb3));
      reset = 1'b1;
      wb_req = '0;
      sensor_distance = {6{8'hff}};
      repeat (10) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;

      // registers come out of reset cleared
      read_register(`REG_STATUS, data);
      check_value(data, 32'd0, "status after reset");
      read_register(`REG_LOCATION, data);
      check_value(data, 32'd0, "location after reset");

      // distinct random distances
      run_sweep(random_distances(1'b1));

      // ties go to the lowest index
      run_sweep({8'd33, 8'd33, 8'd210, 8'd33, 8'd77, 8'd120});
      run_sweep({8'd9, 8'd50, 8'd50, 8'd50, 8'd50, 8'd9});

      // all silent, then only sensor 5 at 165 degrees
      run_sweep({6{8'hff}});
      dists = {6{8'hff}};
      dists[5] = sonar_pkg::distance_t'(1 + ($urandom % 254));
      run_sweep(dists);

      // a second start while busy must not restart the sweep
      start_sweep(random_distances(1'b1));
      while (!power[2]) @(negedge clock);
      write_register(`REG_CONTROL, 32'd1);
      repeat (4) @(negedge clock);
      check_value(32'(power), 32'h4, "power after start write while busy");
      finish_sweep();
      // done holds and no further sweep runs
      repeat (20) @(negedge clock);
      read_register(`REG_STATUS, data);
      check_value(data, 32'd2, "status long after sweep");

      // back to back with fresh distances, repeats allowed
      repeat (3) run_sweep(random_distances(1'b0));

      while (compared != expected_total) @(negedge clock);
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/sonar_pkg.sv
rtl/echo_ranger.sv
rtl/median_of_three.sv
rtl/sweep_locator.sv
rtl/wb_locator_regs.sv
rtl/sonar_locator_top.sv
verification/sonar_locator_props.sv
verification/sonar_locator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the locator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_name=sonar_locator_sim
log_file=sim.log

# compile with timing and assertions enabled
verilator --binary --timing --assert -f all.f --top-module sonar_locator_tb \
   -Mdir "$build_dir" -o "$sim_name"
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "verilator build returned status $build_status"
   exit 1
fi

"./$build_dir/$sim_name" 2>&1 | tee "$log_file"
sim_status=${PIPESTATUS[0]}

if grep -q "test failed" "$log_file"; then
   echo "testbench reported a failure, see $log_file"
   exit 1
fi

# an assertion error or crash also ends the run with a bad status
if [ "$sim_status" -ne 0 ]; then
   echo "simulation returned status $sim_status"
   exit 1
fi

echo "simulation finished cleanly"
exit 0
